//--- hdl/mem_pkg.sv
package mem_pkg;

    // Bus-level vectors
    typedef logic [31:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;
    typedef logic [3:0]  mem_we_t;    // Bit 0 is address byte 0

    // Word offset inside one region, wide enough for VRAM
    typedef logic [14:0] mem_word_addr_t;

    // Size code 3 is not listed and means no access
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        REGION_NONE    = 3'd0,
        REGION_SYSTEM  = 3'd1,
        REGION_INTERN  = 3'd2,
        REGION_PALETTE = 3'd3,
        REGION_VRAM    = 3'd4,
        REGION_OAM     = 3'd5
    } mem_region_t;

    // Region map, byte base and byte size
    localparam mem_addr_t SYSTEM_BASE  = 32'h0000_0000;
    localparam mem_addr_t SYSTEM_SIZE  = 32'h0000_4000;    // 16 KB
    localparam mem_addr_t INTERN_BASE  = 32'h0300_0000;
    localparam mem_addr_t INTERN_SIZE  = 32'h0000_8000;    // 32 KB
    localparam mem_addr_t PALETTE_BASE = 32'h0500_0000;
    localparam mem_addr_t PALETTE_SIZE = 32'h0000_0400;    // 1 KB
    localparam mem_addr_t VRAM_BASE    = 32'h0600_0000;
    localparam mem_addr_t VRAM_SIZE    = 32'h0001_8000;    // 96 KB
    localparam mem_addr_t OAM_BASE     = 32'h0700_0000;
    localparam mem_addr_t OAM_SIZE     = 32'h0000_0400;    // 1 KB

    // Depths in 32-bit words
    localparam int SYSTEM_DEPTH_WORDS  = int'(SYSTEM_SIZE  / 4);
    localparam int INTERN_DEPTH_WORDS  = int'(INTERN_SIZE  / 4);
    localparam int PALETTE_DEPTH_WORDS = int'(PALETTE_SIZE / 4);
    localparam int VRAM_DEPTH_WORDS    = int'(VRAM_SIZE    / 4);
    localparam int OAM_DEPTH_WORDS     = int'(OAM_SIZE     / 4);

    // Word depth of a region; REGION_NONE only ever carries offset zero
    function automatic int region_depth(input mem_region_t region);
        int depth;
        case (region)
            REGION_SYSTEM:  depth = SYSTEM_DEPTH_WORDS;
            REGION_INTERN:  depth = INTERN_DEPTH_WORDS;
            REGION_PALETTE: depth = PALETTE_DEPTH_WORDS;
            REGION_VRAM:    depth = VRAM_DEPTH_WORDS;
            REGION_OAM:     depth = OAM_DEPTH_WORDS;
            default:        depth = 1;
        endcase
        return depth;
    endfunction

endpackage: mem_pkg

//--- hdl/mem_byte_lanes.sv
`timescale 1ns/1ps

// The CPU places write data in its lanes itself
module mem_byte_lanes
    import mem_pkg::*;
(
    input  logic [1:0] addr_lo,
    input  mem_size_t  size,
    input  logic       write,
    output mem_we_t    byte_we
);

    always_comb begin
        byte_we = '0;
        if (write) begin
            case (size)
                MEM_SIZE_BYTE: begin
                    byte_we[addr_lo] = 1'b1;
                end
                MEM_SIZE_HALF: begin
                    if (addr_lo[1]) begin
                        byte_we = 4'b1100;    // Upper half
                    end else begin
                        byte_we = 4'b0011;
                    end
                end
                MEM_SIZE_WORD: begin
                    byte_we = 4'b1111;
                end
                default: begin
                    byte_we = '0;    // Size 3 means no access
                end
            endcase
        end
    end

endmodule: mem_byte_lanes

//--- hdl/mem_region_decode.sv
`timescale 1ns/1ps

module mem_region_decode
    import mem_pkg::*;
(
    input  mem_addr_t      addr,
    output mem_region_t    region,
    output mem_word_addr_t offset
);

    // True when base <= a < base + size
    function automatic logic in_region(
        input mem_addr_t a,
        input mem_addr_t base,
        input mem_addr_t size
    );
        mem_addr_t rel;
        rel = a - base;
        return (a >= base) && (rel < size);
    endfunction

    function automatic mem_word_addr_t word_offset(
        input mem_addr_t a,
        input mem_addr_t base
    );
        mem_addr_t rel;
        rel = a - base;
        return rel[16:2];    // Byte offset to word index
    endfunction

    always_comb begin
        region = REGION_NONE;
        offset = '0;
        if (in_region(addr, SYSTEM_BASE, SYSTEM_SIZE)) begin
            region = REGION_SYSTEM;
            offset = word_offset(addr, SYSTEM_BASE);
        end else if (in_region(addr, INTERN_BASE, INTERN_SIZE)) begin
            region = REGION_INTERN;
            offset = word_offset(addr, INTERN_BASE);
        end else if (in_region(addr, PALETTE_BASE, PALETTE_SIZE)) begin
            region = REGION_PALETTE;
            offset = word_offset(addr, PALETTE_BASE);
        end else if (in_region(addr, VRAM_BASE, VRAM_SIZE)) begin
            region = REGION_VRAM;
            offset = word_offset(addr, VRAM_BASE);
        end else if (in_region(addr, OAM_BASE, OAM_SIZE)) begin
            region = REGION_OAM;
            offset = word_offset(addr, OAM_BASE);
        end

        // Offset must land inside the memory that will be enabled
        a_offset_in_region: assert (int'(offset) < region_depth(region))
            else $error("offset %0d outside region %s", offset, region.name());
    end

endmodule: mem_region_decode

//--- hdl/mem_dp_ram.sv
`timescale 1ns/1ps

module mem_dp_ram
    import mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic           clock,
    input  logic           arst_n,

    // Port A, CPU/DMA side
    input  logic           ena,
    input  mem_we_t        wea,
    input  mem_word_addr_t addra,
    input  mem_data_t      dina,
    output mem_data_t      douta,

    // Port B, graphics side
    input  logic           enb,
    input  mem_word_addr_t addrb,
    output mem_data_t      doutb
);

    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    mem_data_t        mem [DEPTH_WORDS];
    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;

    assign idx_a = addra[IDX_W-1:0];
    assign idx_b = addrb[IDX_W-1:0];

    // Lane writes, untouched lanes keep their bytes
    always_ff @(posedge clock) begin
        if (ena) begin
            for (int i = 0; i < 4; i++) begin
                if (wea[i]) begin
                    mem[idx_a][8*i +: 8] <= dina[8*i +: 8];
                end
            end
        end
    end

    // Both ports read first, the old word comes out during a write
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            douta <= '0;
        end else if (ena) begin
            douta <= mem[idx_a];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            doutb <= '0;
        end else if (enb) begin
            doutb <= mem[idx_b];
        end
    end

    // Decoder upstream keeps enabled offsets inside this block
    a_addra_in_range: assert property (@(posedge clock) disable iff (!arst_n)
        ena |-> int'(addra) < DEPTH_WORDS);
    a_addrb_in_range: assert property (@(posedge clock) disable iff (!arst_n)
        enb |-> int'(addrb) < DEPTH_WORDS);

endmodule: mem_dp_ram

//--- hdl/mem_read_mux.sv
`timescale 1ns/1ps

module mem_read_mux
    import mem_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  mem_region_t region,
    input  mem_data_t   system_rdata,
    input  mem_data_t   intern_rdata,
    input  mem_data_t   palette_rdata,
    input  mem_data_t   vram_rdata,
    input  mem_data_t   oam_rdata,
    output mem_data_t   rdata
);

    mem_region_t region_q;    // Region of last cycle's access

    // Lines up with the one-cycle RAM read
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            region_q <= REGION_NONE;
        end else begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_SYSTEM:  rdata = system_rdata;
            REGION_INTERN:  rdata = intern_rdata;
            REGION_PALETTE: rdata = palette_rdata;
            REGION_VRAM:    rdata = vram_rdata;
            REGION_OAM:     rdata = oam_rdata;
            default:        rdata = '0;    // Unmapped
        endcase
    end

endmodule: mem_read_mux

//--- hdl/mem_top.sv
`timescale 1ns/1ps

module mem_top
    import mem_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,

    // CPU/DMA bus
    input  mem_addr_t bus_addr,
    input  mem_data_t bus_wdata,
    input  mem_size_t bus_size,
    input  logic      bus_write,
    output mem_data_t bus_rdata,

    // Graphics bus, read only
    input  mem_addr_t gfx_addr,
    input  mem_size_t gfx_size,
    output mem_data_t gfx_data
);

    mem_region_t    bus_region;
    mem_region_t    gfx_region;
    mem_word_addr_t bus_offset;
    mem_word_addr_t gfx_offset;
    mem_we_t        bus_we;

    logic bus_system_en, bus_intern_en, bus_palette_en, bus_vram_en, bus_oam_en;
    logic gfx_system_en, gfx_intern_en, gfx_palette_en, gfx_vram_en, gfx_oam_en;

    mem_data_t bus_system_rdata, bus_intern_rdata, bus_palette_rdata;
    mem_data_t bus_vram_rdata, bus_oam_rdata;
    mem_data_t gfx_system_rdata, gfx_intern_rdata, gfx_palette_rdata;
    mem_data_t gfx_vram_rdata, gfx_oam_rdata;

    mem_region_decode u_bus_decode (.addr(bus_addr), .region(bus_region),
                                    .offset(bus_offset));
    mem_region_decode u_gfx_decode (.addr(gfx_addr), .region(gfx_region),
                                    .offset(gfx_offset));

    mem_byte_lanes u_lanes (.addr_lo(bus_addr[1:0]), .size(bus_size),
                            .write(bus_write), .byte_we(bus_we));

    assign bus_system_en  = (bus_region == REGION_SYSTEM);
    assign bus_intern_en  = (bus_region == REGION_INTERN);
    assign bus_palette_en = (bus_region == REGION_PALETTE);
    assign bus_vram_en    = (bus_region == REGION_VRAM);
    assign bus_oam_en     = (bus_region == REGION_OAM);

    assign gfx_system_en  = (gfx_region == REGION_SYSTEM);
    assign gfx_intern_en  = (gfx_region == REGION_INTERN);
    assign gfx_palette_en = (gfx_region == REGION_PALETTE);
    assign gfx_vram_en    = (gfx_region == REGION_VRAM);
    assign gfx_oam_en     = (gfx_region == REGION_OAM);

    // System ROM stays writable for boot loading
    mem_dp_ram #(.DEPTH_WORDS(SYSTEM_DEPTH_WORDS)) u_system_rom (
        .clock(clock), .arst_n(arst_n),
        .ena(bus_system_en), .wea(bus_we), .addra(bus_offset),
        .dina(bus_wdata), .douta(bus_system_rdata),
        .enb(gfx_system_en), .addrb(gfx_offset), .doutb(gfx_system_rdata)
    );

    mem_dp_ram #(.DEPTH_WORDS(INTERN_DEPTH_WORDS)) u_intern_ram (
        .clock(clock), .arst_n(arst_n),
        .ena(bus_intern_en), .wea(bus_we), .addra(bus_offset),
        .dina(bus_wdata), .douta(bus_intern_rdata),
        .enb(gfx_intern_en), .addrb(gfx_offset), .doutb(gfx_intern_rdata)
    );

    mem_dp_ram #(.DEPTH_WORDS(PALETTE_DEPTH_WORDS)) u_palette_ram (
        .clock(clock), .arst_n(arst_n),
        .ena(bus_palette_en), .wea(bus_we), .addra(bus_offset),
        .dina(bus_wdata), .douta(bus_palette_rdata),
        .enb(gfx_palette_en), .addrb(gfx_offset), .doutb(gfx_palette_rdata)
    );

    mem_dp_ram #(.DEPTH_WORDS(VRAM_DEPTH_WORDS)) u_vram (
        .clock(clock), .arst_n(arst_n),
        .ena(bus_vram_en), .wea(bus_we), .addra(bus_offset),
        .dina(bus_wdata), .douta(bus_vram_rdata),
        .enb(gfx_vram_en), .addrb(gfx_offset), .doutb(gfx_vram_rdata)
    );

    mem_dp_ram #(.DEPTH_WORDS(OAM_DEPTH_WORDS)) u_oam (
        .clock(clock), .arst_n(arst_n),
        .ena(bus_oam_en), .wea(bus_we), .addra(bus_offset),
        .dina(bus_wdata), .douta(bus_oam_rdata),
        .enb(gfx_oam_en), .addrb(gfx_offset), .doutb(gfx_oam_rdata)
    );

    mem_read_mux u_bus_rmux (
        .clock(clock), .arst_n(arst_n), .region(bus_region),
        .system_rdata(bus_system_rdata), .intern_rdata(bus_intern_rdata),
        .palette_rdata(bus_palette_rdata), .vram_rdata(bus_vram_rdata),
        .oam_rdata(bus_oam_rdata), .rdata(bus_rdata)
    );

    mem_read_mux u_gfx_rmux (
        .clock(clock), .arst_n(arst_n), .region(gfx_region),
        .system_rdata(gfx_system_rdata), .intern_rdata(gfx_intern_rdata),
        .palette_rdata(gfx_palette_rdata), .vram_rdata(gfx_vram_rdata),
        .oam_rdata(gfx_oam_rdata), .rdata(gfx_data)
    );

    // Graphics fetches are always whole words
    a_gfx_word_fetch: assert property (@(posedge clock) disable iff (!arst_n)
        gfx_size == MEM_SIZE_WORD);

endmodule: mem_top

//--- test/mem_tb.sv
`timescale 1ns/1ps

module mem_tb
    import mem_pkg::*;
();

    localparam int        CLK_PERIOD = 8;
    localparam int        MAX_CYCLES = 5000;
    localparam mem_addr_t IDLE_ADDR  = 32'hFFFF_FFFC;    // Unmapped, harmless to read
    localparam mem_data_t FILL_WORD  = 32'hA5C3_5A3C;

    localparam mem_addr_t REGION_BASES [5] = '{SYSTEM_BASE, INTERN_BASE, PALETTE_BASE,
                                               VRAM_BASE, OAM_BASE};
    localparam mem_addr_t REGION_SIZES [5] = '{SYSTEM_SIZE, INTERN_SIZE, PALETTE_SIZE,
                                               VRAM_SIZE, OAM_SIZE};

    // Gaps, first byte past each region end, top of the address space
    localparam mem_addr_t UNMAPPED_ADDRS [10] = '{
        32'h0000_4000, 32'h0100_0000, 32'h0300_8000, 32'h0400_0000, 32'h0500_0400,
        32'h0580_0000, 32'h0601_8000, 32'h0700_0400, 32'h0800_0000, 32'hFFFF_FFFC
    };

    logic      clock = 1'b0;
    logic      arst_n;
    mem_addr_t bus_addr;
    mem_data_t bus_wdata;
    mem_size_t bus_size;
    logic      bus_write;
    mem_data_t bus_rdata;
    mem_addr_t gfx_addr;
    mem_size_t gfx_size;
    mem_data_t gfx_data;

    mem_data_t model [mem_addr_t];    // Keyed by aligned byte address
    int        seed = 65;
    int        pass_count = 0;
    int        fail_count = 0;
    int        test_errors = 0;
    int        cycle_count = 0;

    mem_top u_dut (
        .clock(clock), .arst_n(arst_n),
        .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_size(bus_size),
        .bus_write(bus_write), .bus_rdata(bus_rdata),
        .gfx_addr(gfx_addr), .gfx_size(gfx_size), .gfx_data(gfx_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic is_mapped(input mem_addr_t a);
        logic hit;
        hit = 1'b0;
        for (int r = 0; r < 5; r++) begin
            if (a >= REGION_BASES[r] && a < REGION_BASES[r] + REGION_SIZES[r]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Byte lanes a bus write touches
    function automatic mem_we_t lanes_for(input logic [1:0] a_lo, input logic [1:0] size,
                                          input logic write);
        mem_we_t we;
        we = 4'b0000;
        if (write) begin
            if (size == 2'd0) begin
                we = 4'b0001 << a_lo;
            end else if (size == 2'd1) begin
                we = a_lo[1] ? 4'b1100 : 4'b0011;
            end else if (size == 2'd2) begin
                we = 4'b1111;
            end
        end
        return we;
    endfunction

    function automatic mem_data_t merge_lanes(input mem_data_t old_word,
                                              input mem_data_t new_word, input mem_we_t we);
        mem_data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic is_known(input mem_addr_t a);
        return !is_mapped(a) || model.exists(a & ~32'h3);
    endfunction

    function automatic mem_data_t model_word(input mem_addr_t a);
        mem_addr_t key;
        mem_data_t word;
        key = a & ~32'h3;
        word = 32'h0;    // Unmapped reads as zero
        if (is_mapped(a) && model.exists(key)) begin
            word = model[key];
        end
        return word;
    endfunction

    task automatic update_model(input mem_addr_t a, input mem_data_t data,
                                input logic [1:0] size, input logic write);
        mem_addr_t key;
        mem_we_t   we;
        key = a & ~32'h3;
        we = lanes_for(a[1:0], size, write);
        if (is_mapped(a) && we != 4'b0000) begin
            if (model.exists(key)) begin
                model[key] = merge_lanes(model[key], data, we);
            end else if (we == 4'b1111) begin
                model[key] = data;
            end
            // Partial write into an unknown word leaves it unknown
        end
    endtask

    task automatic check_word(input string name, input mem_addr_t addr,
                              input mem_data_t expected, input mem_data_t actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s addr=%h expected=%h actual=%h",
                     $time, name, addr, expected, actual);
            test_errors++;
        end
    endtask

    // One clock cycle on both ports, returns 1 ns after the edge
    task automatic run_cycle(input mem_addr_t b_addr, input mem_data_t b_wdata,
                             input logic [1:0] b_size, input logic b_write,
                             input mem_addr_t g_addr);
        bus_addr  = b_addr;
        bus_wdata = b_wdata;
        bus_size  = mem_size_t'(b_size);
        bus_write = b_write;
        gfx_addr  = g_addr;
        @(posedge clock);
        #1;
        bus_write = 1'b0;
    endtask

    task automatic write_bus(input mem_addr_t a, input mem_data_t data, input logic [1:0] size);
        run_cycle(a, data, size, 1'b1, IDLE_ADDR);
        update_model(a, data, size, 1'b1);
    endtask

    task automatic read_bus(input mem_addr_t a);
        mem_data_t expected;
        expected = model_word(a);
        run_cycle(a, 32'h0, 2'd2, 1'b0, IDLE_ADDR);
        check_word("bus_rdata", a, expected, bus_rdata);
    endtask

    task automatic read_gfx(input mem_addr_t a);
        mem_data_t expected;
        expected = model_word(a);
        run_cycle(IDLE_ADDR, 32'h0, 2'd2, 1'b0, a);
        check_word("gfx_data", a, expected, gfx_data);
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic region_ends();
        mem_addr_t first;
        mem_addr_t last;
        check_word("bus_rdata", IDLE_ADDR, 32'h0, bus_rdata);
        check_word("gfx_data", IDLE_ADDR, 32'h0, gfx_data);
        for (int r = 0; r < 5; r++) begin
            first = REGION_BASES[r];
            last = REGION_BASES[r] + REGION_SIZES[r] - 32'h4;
            write_bus(first, 32'hF1F0_0000 | mem_data_t'(r), 2'd2);
            read_bus(first);
            write_bus(last, 32'hE1E0_0000 | mem_data_t'(r), 2'd2);
            read_bus(last);
        end
        report_test("region ends");
    endtask

    task automatic lane_merges();
        mem_addr_t word_addr;
        word_addr = INTERN_BASE + 32'h100;
        for (int lane = 0; lane < 4; lane++) begin
            write_bus(word_addr, FILL_WORD, 2'd2);
            write_bus(word_addr + mem_addr_t'(lane), 32'h1122_3344, 2'd0);
            read_bus(word_addr);
            write_bus(word_addr, FILL_WORD, 2'd2);
            write_bus(word_addr + mem_addr_t'(lane), 32'h5566_7788, 2'd1);
            read_bus(word_addr);
        end
        // Size code 3 must leave the word alone
        write_bus(word_addr, FILL_WORD, 2'd2);
        write_bus(word_addr, 32'hFFFF_FFFF, 2'd3);
        read_bus(word_addr);
        report_test("lane merges");
    endtask

    task automatic gfx_port_reads();
        mem_addr_t a;
        mem_data_t old_word;
        mem_data_t new_word;
        for (int r = 0; r < 5; r++) begin
            a = REGION_BASES[r] + (REGION_SIZES[r] >> 1);
            new_word = 32'h7000_0000 | mem_data_t'(r);
            read_gfx(REGION_BASES[r]);
            write_bus(a, 32'h6000_0000 | mem_data_t'(r), 2'd2);
            read_gfx(a);
            old_word = model_word(a);
            run_cycle(a, new_word, 2'd2, 1'b1, a);    // Write and fetch collide
            check_word("gfx_data", a, old_word, gfx_data);
            check_word("bus_rdata", a, old_word, bus_rdata);
            update_model(a, new_word, 2'd2, 1'b1);
            read_gfx(a);
        end
        report_test("graphics port reads");
    endtask

    task automatic unmapped_accesses();
        foreach (UNMAPPED_ADDRS[i]) begin
            read_bus(UNMAPPED_ADDRS[i]);
            read_gfx(UNMAPPED_ADDRS[i]);
            write_bus(UNMAPPED_ADDRS[i], 32'hDEAD_BEEF, 2'd2);
            read_bus(UNMAPPED_ADDRS[i]);
        end
        // Nothing mapped may have moved
        foreach (model[key]) begin
            read_bus(key);
        end
        report_test("unmapped accesses");
    endtask

    task automatic back_to_back_reads();
        mem_addr_t addrs [$];
        for (int r = 0; r < 5; r++) begin
            addrs.push_back(REGION_BASES[r]);
            addrs.push_back(REGION_BASES[4-r] + REGION_SIZES[4-r] - 32'h4);
        end
        addrs.push_back(IDLE_ADDR);
        foreach (addrs[i]) begin
            read_bus(addrs[i]);
        end
        report_test("back to back reads");
    endtask

    task automatic random_sweep();
        logic [31:0] rnd_bus;
        logic [31:0] rnd_gfx;
        mem_addr_t   b_addr;
        mem_addr_t   g_addr;
        mem_data_t   wdata;
        mem_data_t   exp_bus;
        mem_data_t   exp_gfx;
        logic [1:0]  size;
        logic        wr;
        logic        bus_known;
        logic        gfx_known;
        for (int n = 0; n < 300; n++) begin
            rnd_bus = $random(seed);
            rnd_gfx = $random(seed);
            wdata = $random(seed);
            // 16-word window at the start of a random region
            b_addr = REGION_BASES[int'(rnd_bus[7:0]) % 5]
                   + {26'b0, rnd_bus[11:8], rnd_bus[13:12]};
            g_addr = REGION_BASES[int'(rnd_gfx[7:0]) % 5] + {26'b0, rnd_gfx[11:8], 2'b00};
            wr = rnd_bus[14];
            size = rnd_bus[15] ? 2'd2 : rnd_bus[17:16];
            exp_bus = model_word(b_addr);
            exp_gfx = model_word(g_addr);
            bus_known = is_known(b_addr);
            gfx_known = is_known(g_addr);
            run_cycle(b_addr, wdata, size, wr, g_addr);
            if (bus_known) begin
                check_word("bus_rdata", b_addr, exp_bus, bus_rdata);
            end
            if (gfx_known) begin
                check_word("gfx_data", g_addr, exp_gfx, gfx_data);
            end
            update_model(b_addr, wdata, size, wr);
        end
        report_test("random sweep");
    endtask

    initial begin
        arst_n    = 1'b0;
        bus_addr  = IDLE_ADDR;
        bus_wdata = 32'h0;
        bus_size  = MEM_SIZE_WORD;
        bus_write = 1'b0;
        gfx_addr  = IDLE_ADDR;
        gfx_size  = MEM_SIZE_WORD;    // Tied, graphics always fetches words
        repeat (10) @(posedge clock);
        #1;
        arst_n = 1'b1;

        region_ends();
        lane_merges();
        gfx_port_reads();
        unmapped_accesses();
        back_to_back_reads();
        random_sweep();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule: mem_tb

//--- src.f
hdl/mem_pkg.sv
hdl/mem_byte_lanes.sv
hdl/mem_region_decode.sv
hdl/mem_dp_ram.sv
hdl/mem_read_mux.sv
hdl/mem_top.sv
test/mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_tb -f src.f -Mdir obj_dir

if ! output=$(./obj_dir/Vmem_tb 2>&1); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1
